//--- verilog/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// direct-mapped geometry
`define CACHE_LINES     8
`define WORDS_PER_LINE  4

// datapath widths
`define WORD_BITS       32
`define PROC_ADDR_BITS  30

`endif

//--- verilog/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

    typedef logic [`WORD_BITS-1:0] word_t;

    // word n sits at bits 32n upward
    typedef logic [`WORDS_PER_LINE-1:0][`WORD_BITS-1:0] line_t;

    typedef logic [$clog2(`CACHE_LINES)-1:0] index_t;
    typedef logic [$clog2(`WORDS_PER_LINE)-1:0] offset_t;

    typedef logic [`PROC_ADDR_BITS-$clog2(`CACHE_LINES)-$clog2(`WORDS_PER_LINE)-1:0] tag_t;
    typedef logic [`PROC_ADDR_BITS-$clog2(`WORDS_PER_LINE)-1:0] line_addr_t;

    // word address seen as lookup key or as memory line address
    typedef union packed {
        struct packed {
            tag_t    tag;
            index_t  index;
            offset_t offset;
        } fields;
        struct packed {
            line_addr_t line_addr;
            offset_t    offset;
        } line;
    } proc_addr_u;

endpackage

//--- verilog/line_store_if.sv
`timescale 1ns/1ps

interface line_store_if;

    cache_pkg::index_t   index;
    cache_pkg::tag_t     fill_tag;
    cache_pkg::line_t    fill_data;
    cache_pkg::offset_t  wr_offset;
    cache_pkg::word_t    wr_word;
    logic                fill_en;
    logic                wr_en;

    logic                rd_valid;  // combinational view of the line at index
    logic                rd_dirty;
    cache_pkg::tag_t     rd_tag;
    cache_pkg::line_t    rd_line;

    modport ctrl (
        output index, fill_en, fill_tag, fill_data, wr_en, wr_offset, wr_word,
        input  rd_valid, rd_dirty, rd_tag, rd_line
    );

    modport store (
        input  index, fill_en, fill_tag, fill_data, wr_en, wr_offset, wr_word,
        output rd_valid, rd_dirty, rd_tag, rd_line
    );

endinterface

//--- verilog/line_store.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module line_store (
    input  logic        clk,
    input  logic        proc_reset,
    line_store_if.store ls
);

    logic [`CACHE_LINES-1:0] valid;
    logic [`CACHE_LINES-1:0] dirty;
    cache_pkg::tag_t         tag_mem  [`CACHE_LINES];
    cache_pkg::line_t        data_mem [`CACHE_LINES];

    // zero latency lookup port
    assign ls.rd_valid = valid[ls.index];
    assign ls.rd_dirty = dirty[ls.index];
    assign ls.rd_tag   = tag_mem[ls.index];
    assign ls.rd_line  = data_mem[ls.index];

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (ls.fill_en)
        begin
            valid[ls.index] <= 1'b1;
            dirty[ls.index] <= 1'b0;    // fresh from memory
        end
        else if (ls.wr_en)
        begin
            dirty[ls.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ls.fill_en)
        begin
            tag_mem[ls.index]  <= ls.fill_tag;
            data_mem[ls.index] <= ls.fill_data;
        end
        else if (ls.wr_en)
        begin
            data_mem[ls.index][ls.wr_offset] <= ls.wr_word;   // single word merge
        end
    end

    // the controller only fills outside idle and only writes in idle
    fill_write_exclusive: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(ls.fill_en && ls.wr_en)
    )
    else $error("line_store: fill and word write in the same cycle");

endmodule

//--- verilog/cache_controller.sv
`timescale 1ns/1ps

module cache_controller (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  cache_pkg::proc_addr_u proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    input  cache_pkg::line_t      mem_rdata,
    input  logic                  mem_ready,
    output logic                  proc_stall,
    output cache_pkg::word_t      proc_rdata,
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::line_addr_t mem_addr,
    output cache_pkg::line_t      mem_wdata,
    line_store_if.ctrl            ls
);

    localparam logic [1:0] IDLE       = 2'd0;
    localparam logic [1:0] WRITE_BACK = 2'd1;
    localparam logic [1:0] FILL       = 2'd2;

    logic [1:0] state;
    logic       request;
    logic       hit;
    logic       miss_start;
    logic       wb_done;

    assign request = proc_read | proc_write;
    assign hit     = ls.rd_valid && (ls.rd_tag == proc_addr.fields.tag);

    // read word straight out of the indexed line
    assign proc_rdata = ls.rd_line[proc_addr.fields.offset];

    // only an idle hit lets the request through
    assign proc_stall = request && ((state != IDLE) || !hit);

    assign miss_start = (state == IDLE) && request && !hit;
    assign wb_done    = (state == WRITE_BACK) && mem_ready;

    // line store requests
    assign ls.index     = proc_addr.fields.index;
    assign ls.fill_en   = (state == FILL) && mem_ready;
    assign ls.fill_tag  = proc_addr.fields.tag;
    assign ls.fill_data = mem_rdata;
    assign ls.wr_en     = (state == IDLE) && proc_write && hit;
    assign ls.wr_offset = proc_addr.fields.offset;
    assign ls.wr_word   = proc_wdata;

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            state     <= IDLE;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (miss_start)
                    begin
                        if (ls.rd_dirty)    // victim must go out first
                        begin
                            state     <= WRITE_BACK;
                            mem_write <= 1'b1;
                        end
                        else
                        begin
                            state    <= FILL;
                            mem_read <= 1'b1;
                        end
                    end
                end
                WRITE_BACK:
                begin
                    if (mem_ready)
                    begin
                        state     <= FILL;
                        mem_write <= 1'b0;
                        mem_read  <= 1'b1;
                    end
                end
                FILL:
                begin
                    if (mem_ready)
                    begin
                        state    <= IDLE;   // retried as a hit next cycle
                        mem_read <= 1'b0;
                    end
                end
                default:
                begin
                    state     <= IDLE;
                    mem_read  <= 1'b0;
                    mem_write <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (miss_start)
        begin
            if (ls.rd_dirty)
            begin
                mem_addr  <= {ls.rd_tag, proc_addr.fields.index};  // victim line
                mem_wdata <= ls.rd_line;
            end
            else
            begin
                mem_addr <= proc_addr.line.line_addr;
            end
        end
        else if (wb_done)
        begin
            mem_addr <= proc_addr.line.line_addr;
        end
    end

    mem_rw_exclusive: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write)
    )
    else $error("cache_controller: mem_read and mem_write both high");

    // memory sees a steady request until it answers
    mem_req_hold: assert property (
        @(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) && !mem_ready |=>
            $stable(mem_read) && $stable(mem_write) && $stable(mem_addr)
            && (!mem_write || $stable(mem_wdata))
    )
    else $error("cache_controller: memory request changed before mem_ready");

endmodule

//--- verilog/cache.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache (
    input  logic                       clk,
    input  logic                       proc_reset,
    input  logic                       proc_read,
    input  logic                       proc_write,
    input  logic [`PROC_ADDR_BITS-1:0] proc_addr,
    input  cache_pkg::word_t           proc_wdata,
    output logic                       proc_stall,
    output cache_pkg::word_t           proc_rdata,
    input  cache_pkg::line_t           mem_rdata,
    input  logic                       mem_ready,
    output logic                       mem_read,
    output logic                       mem_write,
    output cache_pkg::line_addr_t      mem_addr,
    output cache_pkg::line_t           mem_wdata
);

    line_store_if ls_bus ();

    cache_controller ctrl_inst (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),    // decoded through the address union
        .proc_wdata (proc_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .ls         (ls_bus.ctrl)
    );

    line_store store_inst (
        .clk        (clk),
        .proc_reset (proc_reset),
        .ls         (ls_bus.store)
    );

endmodule

//--- testbench/cache_mem_model.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_mem_model (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  cache_pkg::line_addr_t mem_addr,
    input  cache_pkg::line_t      mem_wdata,
    output cache_pkg::line_t      mem_rdata,
    output logic                  mem_ready
);

    cache_pkg::line_t store [cache_pkg::line_addr_t];   // only lines written so far
    logic             busy;
    int               wait_cnt;

    function automatic cache_pkg::word_t fill_pattern(cache_pkg::line_addr_t la,
                                                      cache_pkg::offset_t off);
        return (cache_pkg::word_t'({la, off}) * 32'h9e3779b1) ^ 32'h3c5a96e1;
    endfunction

    function automatic cache_pkg::line_t read_line(cache_pkg::line_addr_t la);
        cache_pkg::line_t l;
        if (store.exists(la))
            return store[la];
        for (int i = 0; i < `WORDS_PER_LINE; i++)
            l[i] = fill_pattern(la, cache_pkg::offset_t'(i));
        return l;
    endfunction

    initial
    begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        busy      = 1'b0;
        wait_cnt  = 0;
    end

    always @(negedge clk)
    begin
        if (proc_reset)
        begin
            mem_ready <= 1'b0;
            busy      <= 1'b0;
        end
        else if (busy)
        begin
            if (wait_cnt == 0)
            begin
                if (mem_write)
                    store[mem_addr] = mem_wdata;
                else
                    mem_rdata <= read_line(mem_addr);
                mem_ready <= 1'b1;
                busy      <= 1'b0;
            end
            else
                wait_cnt <= wait_cnt - 1;
        end
        else
        begin
            mem_ready <= 1'b0;    // pulse lasts one cycle
            if (mem_read || mem_write)
            begin
                busy     <= 1'b1;
                wait_cnt <= $urandom_range(3, 0);   // 1 to 4 cycles
            end
        end
    end

endmodule

//--- testbench/cache_tb.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tb;

    localparam int OFF_BITS       = $clog2(`WORDS_PER_LINE);
    localparam int IDX_BITS       = $clog2(`CACHE_LINES);
    localparam int RESET_CYCLES   = 16;
    localparam int RANDOM_OPS     = 300;
    localparam int NUM_OPS        = RANDOM_OPS + 12;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 12 + RESET_CYCLES;

    logic                       clk;
    logic                       proc_reset;
    logic                       proc_read;
    logic                       proc_write;
    logic [`PROC_ADDR_BITS-1:0] proc_addr;
    cache_pkg::word_t           proc_wdata;
    logic                       proc_stall;
    cache_pkg::word_t           proc_rdata;
    cache_pkg::line_t           mem_rdata;
    logic                       mem_ready;
    logic                       mem_read;
    logic                       mem_write;
    cache_pkg::line_addr_t      mem_addr;
    cache_pkg::line_t           mem_wdata;

    cache_pkg::word_t           shadow [logic [`PROC_ADDR_BITS-1:0]];
    logic [`CACHE_LINES-1:0]    res_valid;     // predicted cache contents
    logic [`CACHE_LINES-1:0]    res_dirty;
    cache_pkg::tag_t            res_tag [`CACHE_LINES];
    cache_pkg::line_addr_t      wb_expected [$];
    string                      test_name;

    cache cache_inst (.*);

    cache_mem_model mem_inst (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic cache_pkg::word_t ref_read(logic [`PROC_ADDR_BITS-1:0] addr);
        cache_pkg::line_addr_t la;
        la = cache_pkg::line_addr_t'(addr >> OFF_BITS);
        if (shadow.exists(addr))
            return shadow[addr];
        // same address pattern as the memory model
        return (cache_pkg::word_t'({la, addr[OFF_BITS-1:0]}) * 32'h9e3779b1) ^ 32'h3c5a96e1;
    endfunction

    function automatic cache_pkg::line_t shadow_line(cache_pkg::line_addr_t la);
        cache_pkg::line_t l;
        for (int i = 0; i < `WORDS_PER_LINE; i++)
            l[i] = ref_read({la, OFF_BITS'(i)});
        return l;
    endfunction

    // returns 1 when a direct-mapped cache would hit
    function automatic bit predict_access(logic [`PROC_ADDR_BITS-1:0] addr, bit is_write);
        logic [IDX_BITS-1:0] idx;
        cache_pkg::tag_t     tag;
        bit                  hit;
        idx = addr[OFF_BITS +: IDX_BITS];
        tag = cache_pkg::tag_t'(addr >> (OFF_BITS + IDX_BITS));
        hit = res_valid[idx] && (res_tag[idx] == tag);
        if (!hit)
        begin
            if (res_dirty[idx])
                wb_expected.push_back({res_tag[idx], idx});   // victim goes out first
            res_valid[idx] = 1'b1;
            res_tag[idx]   = tag;
            res_dirty[idx] = 1'b0;
        end
        if (is_write)
            res_dirty[idx] = 1'b1;
        return hit;
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(string name, cache_pkg::word_t expected, cache_pkg::word_t actual);
        if (expected !== actual)
            fail_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic check_line(string name, cache_pkg::line_addr_t exp_addr,
                              cache_pkg::line_t exp_line, cache_pkg::line_addr_t act_addr,
                              cache_pkg::line_t act_line);
        if (exp_addr !== act_addr)
            fail_run($sformatf("error %s: expected %h, actual %h", name, exp_addr, act_addr));
        if (exp_line !== act_line)
            fail_run($sformatf("error %s: expected %h, actual %h", name, exp_line, act_line));
    endtask

    task automatic access(string name, bit is_write, logic [`PROC_ADDR_BITS-1:0] addr,
                          cache_pkg::word_t wdata);
        bit hit;
        int stalls;
        hit       = predict_access(addr, is_write);
        test_name = name;
        stalls    = 0;
        @(negedge clk);
        proc_read  = !is_write;
        proc_write = is_write;
        proc_addr  = addr;
        proc_wdata = wdata;
        @(posedge clk);
        while (proc_stall)
        begin
            stalls++;
            @(posedge clk);
        end
        if (is_write)
            shadow[addr] = wdata;
        else
            check_word(name, ref_read(addr), proc_rdata);
        if (hit && stalls != 0)
            fail_run($sformatf("%s: a hit stalled for %0d cycles", name, stalls));
        if (!hit && stalls == 0)
            fail_run($sformatf("%s: a miss completed without stalling", name));
    endtask

    task automatic idle_check(int cycles);
        @(negedge clk);
        proc_read  = 1'b0;
        proc_write = 1'b0;
        repeat (cycles)
        begin
            @(posedge clk);
            if (proc_stall || mem_read || mem_write)
                fail_run("cache is busy although no request is present");
        end
    endtask

    // every write the memory accepts must match the shadow
    always @(posedge clk)
    begin : wb_monitor
        cache_pkg::line_addr_t exp_addr;
        if (!proc_reset && mem_write && mem_ready)
        begin
            if (wb_expected.size() == 0)
                fail_run("memory write seen where no dirty victim was expected");
            exp_addr = wb_expected.pop_front();
            check_line(test_name, exp_addr, shadow_line(exp_addr), mem_addr, mem_wdata);
        end
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run("timeout: the test sequence did not finish in time");
    end

    initial
    begin
        cache_pkg::tag_t     tag;
        logic [IDX_BITS-1:0] idx;
        logic [OFF_BITS-1:0] off;
        void'($urandom(32'h846893a0));
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        res_valid  = '0;
        res_dirty  = '0;
        test_name  = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        proc_reset = 1'b0;

        idle_check(4);
        access("read_miss", 1'b0, 30'h45, '0);
        access("read_hit", 1'b0, 30'h46, '0);         // same line
        access("write_hit", 1'b1, 30'h46, 32'hdeadbeef);
        access("read_after_write", 1'b0, 30'h46, '0);
        access("evict_dirty", 1'b0, 30'h66, '0);      // index 1 with tag 3
        if (wb_expected.size() != 0)
            fail_run("evict_dirty: the dirty victim was not written back");
        access("reload_written_line", 1'b0, 30'h46, '0);

        for (int i = 0; i < RANDOM_OPS; i++)
        begin
            tag = ($urandom_range(2, 0) == 2) ? 25'h1f0e3 : cache_pkg::tag_t'($urandom_range(1, 0));
            idx = $urandom_range(`CACHE_LINES - 1, 0);
            off = $urandom_range(`WORDS_PER_LINE - 1, 0);
            if ($urandom_range(1, 0))
                access($sformatf("random_write_%0d", i), 1'b1, {tag, idx, off}, $urandom());
            else
                access($sformatf("random_read_%0d", i), 1'b0, {tag, idx, off}, '0);
        end

        idle_check(2);
        if (wb_expected.size() != 0)
        begin
            fail_run("an expected write-back never reached memory");
        end
        else
        begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/line_store_if.sv
verilog/line_store.sv
verilog/cache_controller.sv
verilog/cache.sv
testbench/cache_mem_model.sv
testbench/cache_tb.sv
